/* verilog/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width.
`define LSU_XLEN 32

// store queue size.
`define LSU_SQ_DEPTH 8

// index into the queue, log2 of the depth.
`define LSU_SQ_IDX_W 3

`endif

/* verilog/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0] word_t;
    typedef logic [`LSU_XLEN-1:0] addr_t;        // word aligned.

    typedef logic [`LSU_SQ_IDX_W-1:0] sq_idx_t;
    typedef logic [`LSU_SQ_IDX_W:0]   sq_count_t;  // one extra bit for a full queue.

    // outstanding load tracking in the intake.
    typedef enum logic [1:0] {
        idle,
        load_wait,
        load_done
    } intake_state_t;

endpackage

`default_nettype wire

/* verilog/lsu_request_intake.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_request_intake (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    req_valid,
    output logic                   req_ready,
    input  wire                    req_write,
    input  wire lsu_pkg::addr_t    req_address,
    input  wire lsu_pkg::word_t    req_data,
    output logic                   enq_valid,
    output lsu_pkg::addr_t         enq_address,
    output lsu_pkg::word_t         enq_data,
    input  wire                    full,
    output logic                   lookup_valid,
    output lsu_pkg::addr_t         lookup_address,
    input  wire                    hit_valid,
    input  wire                    hit,
    input  wire lsu_pkg::word_t    hit_data,
    output logic                   read_valid,
    output lsu_pkg::addr_t         read_address,
    input  wire                    read_done,
    input  wire lsu_pkg::word_t    read_data,
    output logic                   load_resp_valid,
    output lsu_pkg::word_t         load_resp_data,
    output logic                   load_resp_forwarded
);

    lsu_pkg::intake_state_t state;
    logic                   ready_armed;
    logic                   accept;
    logic                   req_q_valid;
    logic                   req_q_write;
    lsu_pkg::addr_t         req_q_address;
    lsu_pkg::word_t         req_q_data;
    lsu_pkg::word_t         resp_data_q;

    // a pending load holds off every request, so no younger store can race its read.
    assign req_ready = ready_armed && (state == lsu_pkg::idle) && !(req_write && full);
    assign accept    = req_valid && req_ready;

    assign enq_valid      = req_q_valid && req_q_write;
    assign enq_address    = req_q_address;
    assign enq_data       = req_q_data;
    assign lookup_address = req_q_address;

    assign read_valid   = hit_valid && !hit;   // miss goes to memory.
    assign read_address = req_q_address;

    assign load_resp_valid     = (hit_valid && hit) || (state == lsu_pkg::load_done);
    assign load_resp_data      = (state == lsu_pkg::load_done) ? resp_data_q : hit_data;
    assign load_resp_forwarded = hit_valid && hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= lsu_pkg::idle;
            ready_armed  <= 1'b0;
            req_q_valid  <= 1'b0;
            lookup_valid <= 1'b0;
        end else begin
            ready_armed  <= 1'b1;
            req_q_valid  <= accept;
            lookup_valid <= req_q_valid && !req_q_write;
            case (state)
                lsu_pkg::idle: begin
                    if (accept && !req_write) state <= lsu_pkg::load_wait;
                end
                lsu_pkg::load_wait: begin
                    if (hit_valid && hit) begin
                        state <= lsu_pkg::idle;
                    end else if (read_done) begin
                        state <= lsu_pkg::load_done;
                    end
                end
                default: state <= lsu_pkg::idle;    // load_done lasts one cycle.
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q_write   <= req_write;
            req_q_address <= req_address;
            req_q_data    <= req_data;
        end
        if (read_done) resp_data_q <= read_data;
    end

endmodule

`default_nettype wire

/* verilog/store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module store_queue (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    enq_valid,
    input  wire lsu_pkg::addr_t    enq_address,
    input  wire lsu_pkg::word_t    enq_data,
    output logic                   full,
    input  wire                    lookup_valid,
    input  wire lsu_pkg::addr_t    lookup_address,
    output logic                   hit_valid,
    output logic                   hit,
    output lsu_pkg::word_t         hit_data,
    output logic                   head_valid,
    output lsu_pkg::addr_t         head_address,
    output lsu_pkg::word_t         head_data,
    input  wire                    drain_done
);

    lsu_pkg::addr_t    entry_address [`LSU_SQ_DEPTH];
    lsu_pkg::word_t    entry_data    [`LSU_SQ_DEPTH];
    lsu_pkg::sq_idx_t  head;
    lsu_pkg::sq_idx_t  tail;
    lsu_pkg::sq_count_t count;
    logic              match;
    lsu_pkg::word_t    match_data;

    localparam lsu_pkg::sq_idx_t  LAST_SLOT = lsu_pkg::sq_idx_t'(`LSU_SQ_DEPTH - 1);
    localparam lsu_pkg::sq_count_t CAPACITY = lsu_pkg::sq_count_t'(`LSU_SQ_DEPTH);

    // the intake's enqueue lands one cycle late, so count it as taken already.
    assign full = (count == CAPACITY) ||
                  (enq_valid && (count == CAPACITY - lsu_pkg::sq_count_t'(1)));

    assign head_valid   = (count != '0);
    assign head_address = entry_address[head];
    assign head_data    = entry_data[head];

    // walk from oldest to youngest; a later match overrides an earlier one.
    always_comb begin
        lsu_pkg::sq_idx_t slot;
        match      = 1'b0;
        match_data = '0;
        for (int i = 0; i < `LSU_SQ_DEPTH; i++) begin
            slot = lsu_pkg::sq_idx_t'((int'(head) + i) % `LSU_SQ_DEPTH);
            if ((lsu_pkg::sq_count_t'(i) < count) &&
                (entry_address[slot] == lookup_address)) begin
                match      = 1'b1;
                match_data = entry_data[slot];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            hit_valid <= 1'b0;
            hit       <= 1'b0;
        end else begin
            hit_valid <= lookup_valid;
            hit       <= lookup_valid && match;
            if (enq_valid) begin
                tail <= (tail == LAST_SLOT) ? '0 : tail + 1'b1;
            end
            if (drain_done) begin
                head <= (head == LAST_SLOT) ? '0 : head + 1'b1;   // acked by memory.
            end
            case ({enq_valid, drain_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            entry_address[tail] <= enq_address;
            entry_data[tail]    <= enq_data;
        end
        hit_data <= match_data;
    end

endmodule

`default_nettype wire

/* verilog/axi_lite_port.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_port (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    head_valid,
    input  wire lsu_pkg::addr_t    head_address,
    input  wire lsu_pkg::word_t    head_data,
    output logic                   drain_done,
    input  wire                    read_valid,
    input  wire lsu_pkg::addr_t    read_address,
    output logic                   read_done,
    output lsu_pkg::word_t         read_data,
    output logic                   awvalid,
    input  wire                    awready,
    output lsu_pkg::addr_t         awaddr,
    output logic                   wvalid,
    input  wire                    wready,
    output lsu_pkg::word_t         wdata,
    input  wire                    bvalid,
    output logic                   bready,
    output logic                   arvalid,
    input  wire                    arready,
    output lsu_pkg::addr_t         araddr,
    input  wire                    rvalid,
    output logic                   rready,
    input  wire lsu_pkg::word_t    rdata
);

    logic aw_last;
    logic w_last;

    // each channel is finished once it is low or handshaking this cycle.
    assign aw_last = !awvalid || awready;
    assign w_last  = !wvalid || wready;

    assign drain_done = bready && bvalid;
    assign read_done  = rready && rvalid;
    assign read_data  = rdata;

    // write side keeps one head store in flight.
    always_ff @(posedge clock) begin
        if (reset) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else if (awvalid || wvalid) begin
            if (awready) awvalid <= 1'b0;
            if (wready)  wvalid  <= 1'b0;
            if (aw_last && w_last) bready <= 1'b1;
        end else if (bready) begin
            if (bvalid) bready <= 1'b0;    // queue frees the head on this edge.
        end else if (head_valid) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!awvalid && !wvalid && !bready && head_valid) begin
            awaddr <= head_address;
            wdata  <= head_data;
        end
    end

    // read side.
    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else if (arvalid) begin
            if (arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
        end else if (rready) begin
            if (rvalid) rready <= 1'b0;
        end else if (read_valid) begin
            arvalid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!arvalid && !rready && read_valid) araddr <= read_address;
    end

endmodule

`default_nettype wire

/* verilog/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    req_valid,
    output logic                   req_ready,
    input  wire                    req_write,
    input  wire lsu_pkg::addr_t    req_address,
    input  wire lsu_pkg::word_t    req_data,
    output logic                   load_resp_valid,
    output lsu_pkg::word_t         load_resp_data,
    output logic                   load_resp_forwarded,
    output logic                   awvalid,
    input  wire                    awready,
    output lsu_pkg::addr_t         awaddr,
    output logic                   wvalid,
    input  wire                    wready,
    output lsu_pkg::word_t         wdata,
    input  wire                    bvalid,
    output logic                   bready,
    output logic                   arvalid,
    input  wire                    arready,
    output lsu_pkg::addr_t         araddr,
    input  wire                    rvalid,
    output logic                   rready,
    input  wire lsu_pkg::word_t    rdata
);

    logic           enq_valid;
    lsu_pkg::addr_t enq_address;
    lsu_pkg::word_t enq_data;
    logic           full;
    logic           lookup_valid;
    lsu_pkg::addr_t lookup_address;
    logic           hit_valid;
    logic           hit;
    lsu_pkg::word_t hit_data;
    logic           head_valid;
    lsu_pkg::addr_t head_address;
    lsu_pkg::word_t head_data;
    logic           drain_done;
    logic           read_valid;
    lsu_pkg::addr_t read_address;
    logic           read_done;
    lsu_pkg::word_t read_data;

    lsu_request_intake u_intake (
        .clock, .reset,
        .req_valid, .req_ready, .req_write, .req_address, .req_data,
        .enq_valid, .enq_address, .enq_data, .full,
        .lookup_valid, .lookup_address, .hit_valid, .hit, .hit_data,
        .read_valid, .read_address, .read_done, .read_data,
        .load_resp_valid, .load_resp_data, .load_resp_forwarded
    );

    store_queue u_store_queue (
        .clock, .reset,
        .enq_valid, .enq_address, .enq_data, .full,
        .lookup_valid, .lookup_address, .hit_valid, .hit, .hit_data,
        .head_valid, .head_address, .head_data, .drain_done
    );

    // AXI4-Lite master toward memory.
    axi_lite_port u_axi_port (
        .clock, .reset,
        .head_valid, .head_address, .head_data, .drain_done,
        .read_valid, .read_address, .read_done, .read_data,
        .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata,
        .bvalid, .bready, .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata
    );

endmodule

`default_nettype wire

/* tb/axi_lite_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_mem_model (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 stall,        // holds awready and wready low.
    input  wire [2:0]           resp_delay,   // idle cycles before bvalid or rvalid.
    input  wire                 awvalid,
    output logic                awready,
    input  wire lsu_pkg::addr_t awaddr,
    input  wire                 wvalid,
    output logic                wready,
    input  wire lsu_pkg::word_t wdata,
    output logic                bvalid,
    input  wire                 bready,
    input  wire                 arvalid,
    output logic                arready,
    input  wire lsu_pkg::addr_t araddr,
    output logic                rvalid,
    input  wire                 rready,
    output lsu_pkg::word_t      rdata,
    output logic                write_commit,
    output lsu_pkg::addr_t      commit_address,
    output lsu_pkg::word_t      commit_data
);

    lsu_pkg::word_t mem [64];
    logic           aw_have;
    logic           w_have;
    logic           b_wait;
    logic           r_wait;
    logic [2:0]     b_count;
    logic [2:0]     r_count;

    // no new AW or W until B is taken.
    assign awready = !stall && !aw_have && !b_wait && !bvalid;
    assign wready  = !stall && !w_have && !b_wait && !bvalid;
    assign arready = !r_wait && !rvalid;

    assign write_commit = aw_have && w_have;

    always @(posedge clock) begin
        if (reset) begin
            aw_have <= 1'b0;
            w_have  <= 1'b0;
            b_wait  <= 1'b0;
            bvalid  <= 1'b0;
            r_wait  <= 1'b0;
            rvalid  <= 1'b0;
            for (int i = 0; i < 64; i++) begin
                mem[i] <= 32'h6d5a_0000 ^ (i * 32'h0001_0101);
            end
        end else begin
            if (awvalid && awready) begin
                aw_have        <= 1'b1;
                commit_address <= awaddr;
            end
            if (wvalid && wready) begin
                w_have      <= 1'b1;
                commit_data <= wdata;
            end
            if (write_commit) begin
                mem[commit_address[7:2]] <= commit_data;
                aw_have <= 1'b0;
                w_have  <= 1'b0;
                b_wait  <= 1'b1;
                b_count <= resp_delay;
            end
            if (b_wait) begin
                if (b_count == 3'd0) begin
                    b_wait <= 1'b0;
                    bvalid <= 1'b1;
                end else begin
                    b_count <= b_count - 3'd1;
                end
            end
            if (bvalid && bready) bvalid <= 1'b0;
            if (arvalid && arready) begin
                r_wait  <= 1'b1;
                r_count <= resp_delay;
                rdata   <= mem[araddr[7:2]];   // data taken at the address handshake.
            end
            if (r_wait) begin
                if (r_count == 3'd0) begin
                    r_wait <= 1'b0;
                    rvalid <= 1'b1;
                end else begin
                    r_count <= r_count - 3'd1;
                end
            end
            if (rvalid && rready) rvalid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* tb/tb_lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

    localparam int random_ops  = 2000;
    localparam int cycle_limit = random_ops * 8 + 4000;  // about eight cycles per random op.

    logic           clock;
    logic           reset;
    logic           req_valid;
    logic           req_ready;
    logic           req_write;
    lsu_pkg::addr_t req_address;
    lsu_pkg::word_t req_data;
    logic           load_resp_valid;
    lsu_pkg::word_t load_resp_data;
    logic           load_resp_forwarded;
    logic           awvalid;
    logic           awready;
    lsu_pkg::addr_t awaddr;
    logic           wvalid;
    logic           wready;
    lsu_pkg::word_t wdata;
    logic           bvalid;
    logic           bready;
    logic           arvalid;
    logic           arready;
    lsu_pkg::addr_t araddr;
    logic           rvalid;
    logic           rready;
    lsu_pkg::word_t rdata;
    logic           stall;
    logic [2:0]     resp_delay;
    logic           write_commit;
    lsu_pkg::addr_t commit_address;
    lsu_pkg::word_t commit_data;

    lsu_pkg::word_t shadow [64];
    lsu_pkg::addr_t exp_write_addr [$];
    lsu_pkg::word_t exp_write_data [$];
    int             stores_in_flight;
    logic           load_pending;
    lsu_pkg::word_t load_expect;
    int             load_edge;
    logic           last_forwarded;
    int             cycles;
    logic [31:0]    lcg_state;
    logic           vary_memory;

    lsu_top DUT (.*);
    axi_lite_mem_model mem_model (.*);

    function automatic lsu_pkg::word_t fill_word(input int index);
        return 32'h6d5a_0000 ^ (index * 32'h0001_0101);
    endfunction

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) report_failure($sformatf("timeout after %0d cycles", cycles));
    end

    // shadow memory and response checks.
    always @(negedge clock) begin
        if (!reset && req_valid && req_ready) begin
            if (req_write) begin
                shadow[req_address[7:2]] = req_data;
                exp_write_addr.push_back(req_address);
                exp_write_data.push_back(req_data);
                stores_in_flight++;
            end else begin
                load_expect  = shadow[req_address[7:2]];
                load_pending = 1'b1;
                load_edge    = cycles + 1;
            end
        end
        if (bvalid && bready) stores_in_flight--;
        if (write_commit) begin
            assert (exp_write_addr.size() != 0)
                else report_failure("memory received a write that no store asked for");
            assert (commit_address == exp_write_addr[0])
                else report_failure($sformatf("ERR %0t awaddr got %h expected %h",
                                              $time, commit_address, exp_write_addr[0]));
            assert (commit_data == exp_write_data[0])
                else report_failure($sformatf("ERR %0t wdata got %h expected %h",
                                              $time, commit_data, exp_write_data[0]));
            void'(exp_write_addr.pop_front());
            void'(exp_write_data.pop_front());
        end
        if (load_resp_valid) begin
            assert (load_pending) else report_failure("load response with no load outstanding");
            assert (load_resp_data == load_expect)
                else report_failure($sformatf("ERR %0t load_resp_data got %h expected %h",
                                              $time, load_resp_data, load_expect));
            assert (!load_resp_forwarded || (cycles - load_edge == 2))
                else report_failure($sformatf("forwarded load answered %0d edges after transfer",
                                              cycles - load_edge));
            last_forwarded = load_resp_forwarded;
            load_pending   = 1'b0;
        end
    end

    task automatic require_low(input logic value, input string name);
        assert (value == 1'b0)
            else report_failure($sformatf("ERR %0t %s got %b expected 0", $time, name, value));
    endtask

    task automatic check_outputs_idle();
        require_low(req_ready, "req_ready");
        require_low(load_resp_valid, "load_resp_valid");
        require_low(awvalid, "awvalid");
        require_low(wvalid, "wvalid");
        require_low(arvalid, "arvalid");
        require_low(bready, "bready");
        require_low(rready, "rready");
    endtask

    // called 2 ns after an edge; returns 2 ns after the transfer edge.
    task automatic send_request(input logic write, input lsu_pkg::addr_t addr,
                                input lsu_pkg::word_t data);
        logic        accepted;
        logic [31:0] r;
        req_valid   = 1'b1;
        req_write   = write;
        req_address = addr;
        req_data    = data;
        do begin
            @(negedge clock);
            accepted = req_ready;
            @(posedge clock);
            #2;
            if (vary_memory) begin
                r          = next_random();
                stall      = (r[31:30] == 2'b00);
                resp_delay = {1'b0, r[28:27]};
            end
        end while (!accepted);
        req_valid = 1'b0;
    endtask

    task automatic wait_load();
        while (load_pending) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic wait_drained();
        while (stores_in_flight != 0 || exp_write_addr.size() != 0) begin
            @(posedge clock);
            #2;
        end
    endtask

    task automatic expect_forwarded(input logic want);
        assert (last_forwarded == want)
            else report_failure($sformatf("ERR %0t load_resp_forwarded got %b expected %b",
                                          $time, last_forwarded, want));
    endtask

    task automatic compare_memory_to_shadow();
        for (int i = 0; i < 64; i++) begin
            assert (mem_model.mem[i] == shadow[i])
                else report_failure($sformatf("ERR %0t mem[%0d] got %h expected %h",
                                              $time, i, mem_model.mem[i], shadow[i]));
        end
    endtask

    initial begin
        logic [31:0] r;
        lcg_state        = 32'd7033;
        cycles           = 0;
        reset            = 1'b1;
        req_valid        = 1'b0;
        req_write        = 1'b0;
        req_address      = '0;
        req_data         = '0;
        stall            = 1'b0;
        resp_delay       = 3'd2;
        vary_memory      = 1'b0;
        load_pending     = 1'b0;
        load_expect      = '0;
        load_edge        = 0;
        last_forwarded   = 1'b0;
        stores_in_flight = 0;
        for (int i = 0; i < 64; i++) shadow[i] = fill_word(i);
        repeat (4) @(posedge clock);
        #2;
        check_outputs_idle();
        reset = 1'b0;
        @(negedge clock);
        check_outputs_idle();   // ready stays low one more cycle.
        @(posedge clock);
        #2;

        stall = 1'b1;
        send_request(1'b1, 32'h80, 32'hcafe_0001);
        send_request(1'b0, 32'h80, '0);
        wait_load();
        expect_forwarded(1'b1);
        send_request(1'b1, 32'h84, 32'h1111_0001);
        send_request(1'b1, 32'h84, 32'h2222_0002);
        send_request(1'b1, 32'h84, 32'h3333_0003);
        send_request(1'b0, 32'h84, '0);
        wait_load();
        expect_forwarded(1'b1);
        stall = 1'b0;
        wait_drained();

        // queue empty now, so loads go to memory.
        send_request(1'b0, 32'h80, '0);
        wait_load();
        expect_forwarded(1'b0);
        send_request(1'b0, 32'h90, '0);
        wait_load();
        expect_forwarded(1'b0);

        stall = 1'b1;
        for (int i = 0; i < 8; i++) send_request(1'b1, 32'hc0 + 32'(i * 4), next_random());
        req_valid   = 1'b1;
        req_write   = 1'b1;
        req_address = 32'he0;
        req_data    = 32'h9999_0009;
        repeat (10) begin
            @(negedge clock);
            assert (!req_ready)
                else report_failure($sformatf("ERR %0t req_ready got 1 expected 0", $time));
        end
        @(posedge clock);
        #2;
        stall = 1'b0;
        send_request(1'b1, 32'he0, 32'h9999_0009);
        wait_drained();
        compare_memory_to_shadow();

        vary_memory = 1'b1;
        repeat (random_ops) begin
            r = next_random();
            send_request(r[30], 32'(r[27:24]) << 2, next_random());
        end
        vary_memory = 1'b0;
        stall       = 1'b0;
        wait_load();
        wait_drained();
        compare_memory_to_shadow();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verilog
verilog/lsu_pkg.sv
verilog/lsu_request_intake.sv
verilog/store_queue.sv
verilog/axi_lite_port.sv
verilog/lsu_top.sv
tb/axi_lite_mem_model.sv
tb/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu_store_queue

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_request_intake.sv
      - verilog/store_queue.sv
      - verilog/axi_lite_port.sv
      - verilog/lsu_top.sv
  - target: test
    files:
      - tb/axi_lite_mem_model.sv
      - tb/tb_lsu.sv
